/* vlog.f */
fifo_pkg.sv
fifo_ram.sv
fifo_ctrl.sv
fifo_cfg_regs.sv
fifo_top.sv
tb_fifo.sv

/* run.sh */
#!/bin/sh
# Build and run the FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_fifo -o tb_fifo_sim
out=$(./obj_dir/tb_fifo_sim)
echo "$out"

if echo "$out" | grep -q "^Simulation PASSED$"; then
    exit 0
else
    exit 1
fi

/* tb_fifo.sv */
// Testbench for the single-clock FIFO at default parameters (DEPTH 13)
// A queue model predicts data, count and flags; concurrent assertions compare
// Inputs change on the falling edge; predictions trail the DUT by one edge
module tb_fifo;

    import fifo_pkg::*;

    localparam int DATA_WIDTH = 32;
    localparam int DEPTH      = 13;
    // Tests run for well under 200 cycles, so this only trips on a hang
    localparam int MAX_CYCLES = 2000;

    logic                   clk;
    logic                   reset;
    logic                   write;
    logic                   read;
    logic [DATA_WIDTH-1:0]  data_in;
    logic                   cfg_write;
    cfg_addr_e              cfg_addr;
    logic [COUNT_WIDTH-1:0] cfg_data;
    logic [DATA_WIDTH-1:0]  data_out;
    logic                   valid_out;
    fifo_status_t           status;

    // Reference model and its thresholds
    logic [DATA_WIDTH-1:0]  model[$];
    logic [COUNT_WIDTH-1:0] af_lvl = COUNT_WIDTH'(DEPTH - 2);
    logic [COUNT_WIDTH-1:0] ae_lvl = COUNT_WIDTH'(2);

    // Prediction for the coming edge, and the one now visible on the DUT
    logic                   pend_valid;
    logic [DATA_WIDTH-1:0]  pend_data;
    fifo_status_t           pend_status;
    logic                   exp_valid;
    logic [DATA_WIDTH-1:0]  exp_data;
    fifo_status_t           exp_status;

    integer seed = 32'hb61f95cc;
    int     error_count;
    int     test_errors;
    int     tests_passed;
    int     tests_failed;
    int     cycles;

    fifo_top #(
        .DATA_WIDTH(DATA_WIDTH),
        .DEPTH     (DEPTH)
    ) uut (
        .clk      (clk),
        .reset    (reset),
        .write    (write),
        .read     (read),
        .data_in  (data_in),
        .cfg_write(cfg_write),
        .cfg_addr (cfg_addr),
        .cfg_data (cfg_data),
        .data_out (data_out),
        .valid_out(valid_out),
        .status   (status)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Model helpers
    //////////////////////////////////////////////////

    // Flags straight from the occupancy rules
    function automatic fifo_status_t predict_status(input int size);
        fifo_status_t s;
        s.count        = COUNT_WIDTH'(size);
        s.full         = (size == DEPTH);
        s.empty        = (size == 0);
        s.almost_full  = (size >= int'(af_lvl));
        s.almost_empty = (size <= int'(ae_lvl));
        return s;
    endfunction

    task automatic report_mismatch(input string name, input logic [DATA_WIDTH-1:0] got,
                                   input logic [DATA_WIDTH-1:0] want);
        error_count++;
        $display("** Error at %0t: %s got %0h expected %0h", $time, name, got, want);
    endtask

    // One cycle of stimulus; commit the last prediction, then predict the next edge
    task automatic drive_cycle(input logic w, input logic r, input logic [DATA_WIDTH-1:0] d,
                               input logic cw, input cfg_addr_e ca,
                               input logic [COUNT_WIDTH-1:0] cd);
        logic push_ok;
        logic pop_ok;
        @(negedge clk);
        exp_valid  = pend_valid;
        exp_data   = pend_data;
        exp_status = pend_status;
        push_ok    = w && (model.size() < DEPTH);
        pop_ok     = r && (model.size() > 0);
        pend_valid = pop_ok;
        if (pop_ok) begin
            pend_data = model.pop_front();
        end
        if (push_ok) begin
            model.push_back(d);
        end
        // Levels written now only count from the following edge
        pend_status = predict_status(model.size());
        if (cw) begin
            if (ca == CFG_AF_LEVEL) begin
                af_lvl = cd;
            end else begin
                ae_lvl = cd;
            end
        end
        write     = w;
        read      = r;
        data_in   = d;
        cfg_write = cw;
        cfg_addr  = ca;
        cfg_data  = cd;
    endtask

    task automatic do_cycle(input logic w, input logic r);
        logic [DATA_WIDTH-1:0] word;
        word = $random(seed);
        drive_cycle(w, r, word, 1'b0, CFG_AF_LEVEL, '0);
    endtask

    task automatic write_level(input cfg_addr_e ca, input logic [COUNT_WIDTH-1:0] cd);
        drive_cycle(1'b0, 1'b0, '0, 1'b1, ca, cd);
    endtask

    // Two idle cycles so the last result is checked before the report
    task automatic finish_test(input string name);
        do_cycle(1'b0, 1'b0);
        do_cycle(1'b0, 1'b0);
        if (error_count == test_errors) begin
            tests_passed++;
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: fail with %0d errors", name, error_count - test_errors);
        end
        test_errors = error_count;
    endtask

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    a_valid: assert property (@(posedge clk) disable iff (reset) valid_out == exp_valid)
        else report_mismatch("valid_out", $sampled(valid_out), exp_valid);
    a_data: assert property (@(posedge clk) disable iff (reset)
        exp_valid |-> (data_out == exp_data))
        else report_mismatch("data_out", $sampled(data_out), exp_data);
    a_count: assert property (@(posedge clk) disable iff (reset)
        status.count == exp_status.count)
        else report_mismatch("status.count", $sampled(status.count), exp_status.count);
    a_full: assert property (@(posedge clk) disable iff (reset)
        status.full == exp_status.full)
        else report_mismatch("status.full", $sampled(status.full), exp_status.full);
    a_empty: assert property (@(posedge clk) disable iff (reset)
        status.empty == exp_status.empty)
        else report_mismatch("status.empty", $sampled(status.empty), exp_status.empty);
    a_almost_full: assert property (@(posedge clk) disable iff (reset)
        status.almost_full == exp_status.almost_full)
        else report_mismatch("status.almost_full", $sampled(status.almost_full),
                             exp_status.almost_full);
    a_almost_empty: assert property (@(posedge clk) disable iff (reset)
        status.almost_empty == exp_status.almost_empty)
        else report_mismatch("status.almost_empty", $sampled(status.almost_empty),
                             exp_status.almost_empty);

    // Hang guard
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        reset     = 1'b1;
        write     = 1'b0;
        read      = 1'b0;
        data_in   = '0;
        cfg_write = 1'b0;
        cfg_addr  = CFG_AF_LEVEL;
        cfg_data  = '0;
        pend_valid  = 1'b0;
        pend_data   = '0;
        pend_status = predict_status(0);
        exp_valid   = 1'b0;
        exp_data    = '0;
        exp_status  = predict_status(0);
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Reset state held while idle
        repeat (3) do_cycle(1'b0, 1'b0);
        finish_test("reset_state");

        repeat (8) do_cycle(1'b1, 1'b0);
        repeat (8) do_cycle(1'b0, 1'b1);
        finish_test("order_and_data");

        // Last three pushes land on a full FIFO
        repeat (16) do_cycle(1'b1, 1'b0);
        repeat (13) do_cycle(1'b0, 1'b1);
        finish_test("overflow");

        repeat (3) do_cycle(1'b0, 1'b1);
        finish_test("underflow");

        // Middle, full and empty cases of push with pop
        repeat (6) do_cycle(1'b1, 1'b0);
        repeat (4) do_cycle(1'b1, 1'b1);
        repeat (7) do_cycle(1'b1, 1'b0);
        do_cycle(1'b1, 1'b1);
        repeat (12) do_cycle(1'b0, 1'b1);
        do_cycle(1'b1, 1'b1);
        do_cycle(1'b0, 1'b1);
        finish_test("push_pop_same_cycle");

        write_level(CFG_AF_LEVEL, 8'd5);
        write_level(CFG_AE_LEVEL, 8'd3);
        repeat (13) do_cycle(1'b1, 1'b0);
        repeat (13) do_cycle(1'b0, 1'b1);
        finish_test("thresholds");

        $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* fifo_top.sv */
// Single-clock FIFO top level
// DEPTH may be any value from 2 to 255; data width is free
// One-cycle read latency, no handshake, overflow and underflow are dropped
module fifo_top #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH      = 13
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             write,
    input  logic                             read,
    input  logic [DATA_WIDTH-1:0]            data_in,
    input  logic                             cfg_write,
    input  fifo_pkg::cfg_addr_e              cfg_addr,
    input  logic [fifo_pkg::COUNT_WIDTH-1:0] cfg_data,
    output logic [DATA_WIDTH-1:0]            data_out,
    output logic                             valid_out,
    output fifo_pkg::fifo_status_t           status
);

    import fifo_pkg::*;

    localparam int PTR_WIDTH = $clog2(DEPTH);

    //////////////////////////////////////////////////
    // Internal nets
    //////////////////////////////////////////////////

    fifo_cfg_t            cfg;
    logic                 wr_en;
    logic                 rd_en;
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;

    // Threshold registers
    fifo_cfg_regs #(
        .DEPTH(DEPTH)
    ) u_cfg_regs (
        .clk      (clk),
        .reset    (reset),
        .cfg_write(cfg_write),
        .cfg_addr (cfg_addr),
        .cfg_data (cfg_data),
        .cfg      (cfg)
    );

    // Pointers, count and flags
    fifo_ctrl #(
        .DEPTH(DEPTH)
    ) u_ctrl (
        .clk   (clk),
        .reset (reset),
        .write (write),
        .read  (read),
        .cfg   (cfg),
        .wr_en (wr_en),
        .rd_en (rd_en),
        .wr_ptr(wr_ptr),
        .rd_ptr(rd_ptr),
        .status(status)
    );

    // Storage
    fifo_ram #(
        .DATA_WIDTH(DATA_WIDTH),
        .DEPTH     (DEPTH)
    ) u_ram (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .wr_ptr   (wr_ptr),
        .rd_ptr   (rd_ptr),
        .data_in  (data_in),
        .data_out (data_out),
        .valid_out(valid_out)
    );

endmodule

/* fifo_cfg_regs.sv */
// Threshold registers for the almost-full and almost-empty flags
// Written by a one-cycle strobe; new levels take effect from the next edge
// Levels are not range checked, so a level above DEPTH pins its flag
module fifo_cfg_regs #(
    parameter int DEPTH = 13
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               cfg_write,
    input  fifo_pkg::cfg_addr_e                cfg_addr,
    input  logic [fifo_pkg::COUNT_WIDTH-1:0]   cfg_data,
    output fifo_pkg::fifo_cfg_t                cfg
);

    import fifo_pkg::*;

    //////////////////////////////////////////////////
    // Reset levels
    //////////////////////////////////////////////////

    // Almost full two words short of full
    localparam logic [COUNT_WIDTH-1:0] AF_RESET = COUNT_WIDTH'(DEPTH - 2);
    // Almost empty at two words or fewer
    localparam logic [COUNT_WIDTH-1:0] AE_RESET = COUNT_WIDTH'(2);

    //////////////////////////////////////////////////
    // Register write
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg.af_level <= AF_RESET;
            cfg.ae_level <= AE_RESET;
        end else if (cfg_write) begin
            // Address decode, only the selected level moves
            case (cfg_addr)
                CFG_AF_LEVEL: cfg.af_level <= cfg_data;
                CFG_AE_LEVEL: cfg.ae_level <= cfg_data;
            endcase
        end
    end

endmodule

/* fifo_ctrl.sv */
// Pointer and occupancy control for the FIFO
// Pushes at full and pops at empty are dropped without any stall
// Flags are registered and always agree with the count of the same cycle
module fifo_ctrl #(
    parameter int DEPTH      = 13,
    localparam int PTR_WIDTH = $clog2(DEPTH)
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   write,
    input  logic                   read,
    input  fifo_pkg::fifo_cfg_t    cfg,
    output logic                   wr_en,
    output logic                   rd_en,
    output logic [PTR_WIDTH-1:0]   wr_ptr,
    output logic [PTR_WIDTH-1:0]   rd_ptr,
    output fifo_pkg::fifo_status_t status
);

    import fifo_pkg::*;

    // Last valid index and full level at the working widths
    localparam logic [PTR_WIDTH-1:0]   LAST_PTR   = PTR_WIDTH'(DEPTH - 1);
    localparam logic [COUNT_WIDTH-1:0] FULL_COUNT = COUNT_WIDTH'(DEPTH);

    logic [COUNT_WIDTH-1:0] count_next;

    // Step a pointer, wrapping at DEPTH-1 for non power-of-two depths
    function automatic logic [PTR_WIDTH-1:0] ptr_step(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == LAST_PTR) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    //////////////////////////////////////////////////
    // Request gating
    //////////////////////////////////////////////////

    // Each request is judged on its own flag only
    assign wr_en = write && !status.full;
    assign rd_en = read && !status.empty;

    // Simultaneous push and pop leaves the count alone
    always_comb begin
        case ({wr_en, rd_en})
            2'b10:   count_next = status.count + 1'b1;
            2'b01:   count_next = status.count - 1'b1;
            default: count_next = status.count;
        endcase
    end

    //////////////////////////////////////////////////
    // Pointers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_step(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_step(rd_ptr);
            end
        end
    end

    //////////////////////////////////////////////////
    // Count and flags
    //////////////////////////////////////////////////

    // Flags come from the next count, so they line up with it after the edge
    // Thresholds are sampled as currently held by the config block
    always_ff @(posedge clk) begin
        if (reset) begin
            status.count        <= '0;
            status.full         <= 1'b0;
            status.empty        <= 1'b1;
            status.almost_full  <= 1'b0;
            status.almost_empty <= 1'b1;
        end else begin
            status.count        <= count_next;
            status.full         <= (count_next == FULL_COUNT);
            status.empty        <= (count_next == '0);
            status.almost_full  <= (count_next >= cfg.af_level);
            status.almost_empty <= (count_next <= cfg.ae_level);
        end
    end

    // Occupancy stays within the array
    a_count_range: assert property (@(posedge clk) disable iff (reset)
        status.count <= FULL_COUNT);
    // Registered flags must track the count, checked through the enables
    a_no_push_full: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> (status.count < FULL_COUNT));
    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        rd_en |-> (status.count != '0));

endmodule

/* fifo_ram.sv */
// FIFO storage, one write port and one registered read port
// Enables come pre-gated by the controller; no full or empty test here
// Read data appears one cycle after rd_en with a single-cycle valid strobe
module fifo_ram #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH      = 13,
    localparam int PTR_WIDTH = $clog2(DEPTH)
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wr_en,
    input  logic                  rd_en,
    input  logic [PTR_WIDTH-1:0]  wr_ptr,
    input  logic [PTR_WIDTH-1:0]  rd_ptr,
    input  logic [DATA_WIDTH-1:0] data_in,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  valid_out
);

    // Storage array, contents undefined after reset
    logic [DATA_WIDTH-1:0] mem [DEPTH];

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= data_in;
        end
    end

    //////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////

    // data_out holds its last word once the strobe drops
    always_ff @(posedge clk) begin
        if (reset) begin
            data_out  <= '0;
            valid_out <= 1'b0;
        end else begin
            valid_out <= rd_en;
            if (rd_en) begin
                data_out <= mem[rd_ptr];
            end
        end
    end

    // Pointers must land inside the array whenever they are used
    a_wr_ptr_range: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> (int'(wr_ptr) < DEPTH));
    a_rd_ptr_range: assert property (@(posedge clk) disable iff (reset)
        rd_en |-> (int'(rd_ptr) < DEPTH));

endmodule

/* fifo_pkg.sv */
// Shared types for the synchronous FIFO
// Count and thresholds are fixed at 8 bits, so DEPTH must stay at or below 255
package fifo_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    // Occupancy count and threshold width
    localparam int COUNT_WIDTH = 8;

    //////////////////////////////////////////////////
    // Configuration register map
    //////////////////////////////////////////////////

    // One address bit selects between the two thresholds
    typedef enum logic [0:0] {
        CFG_AF_LEVEL = 1'b0,
        CFG_AE_LEVEL = 1'b1
    } cfg_addr_e;

    // Threshold pair, config block to controller (16 bits)
    typedef struct packed {
        logic [COUNT_WIDTH-1:0] af_level;
        logic [COUNT_WIDTH-1:0] ae_level;
    } fifo_cfg_t;

    //////////////////////////////////////////////////
    // Status
    //////////////////////////////////////////////////

    // Registered flags plus occupancy (12 bits)
    typedef struct packed {
        logic                   full;
        logic                   empty;
        logic                   almost_full;
        logic                   almost_empty;
        logic [COUNT_WIDTH-1:0] count;
    } fifo_status_t;

endpackage
